//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_sv32_mmu
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --timescale 1ns/10ps
SIM_FLAGS  := --binary --timing --timescale 1ns/10ps -j 0
PASS_MSG   := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# exit status comes from the search for the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
verilog/sv32_pkg.sv
verilog/mmu_pkg.sv
verilog/tlb_if.sv
verilog/tlb_assoc.sv
verilog/sv32_walker.sv
verilog/sv32_mmu.sv
tests/pt_mem_model.sv
tests/tb_sv32_mmu.sv

//--- tests/pt_mem_model.sv
// page table memory; only address bits 15:2 decode, so every table must sit below 64 KiB
`timescale 1ns/10ps
`default_nettype none

module pt_mem_model #(
  parameter int WORD_BITS = 14
) (
  input  wire logic        clk,
  input  wire logic        resetn,
  input  wire logic        valid_i,
  input  wire logic [31:0] addr_i,
  output logic             ready_o,
  output logic [31:0]      rdata_o
);

  logic [31:0] mem [2**WORD_BITS];
  integer      seed;
  logic [31:0] draw;
  logic        pending;
  logic [1:0]  wait_cnt;

  // every entry starts invalid
  initial begin
    seed = 32'h93e4;
    for (int i = 0; i < 2**WORD_BITS; i++) begin
      mem[i] = 32'h0;
    end
  end

  // backdoor for building page tables
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[WORD_BITS+1:2]] = data;
  endtask

  always @(posedge clk) begin
    if (!resetn) begin
      ready_o  <= 1'b0;
      rdata_o  <= 32'h0;
      pending  <= 1'b0;
      wait_cnt <= 2'd0;
    end else if (ready_o) begin
      // one-cycle ready pulse ends the read
      ready_o <= 1'b0;
      pending <= 1'b0;
    end else if (valid_i && !pending) begin
      // new read, draw 0 to 3 stall cycles
      draw     = $random(seed);
      pending  <= 1'b1;
      wait_cnt <= draw[1:0];
    end else if (valid_i && (wait_cnt != 2'd0)) begin
      wait_cnt <= wait_cnt - 2'd1;
    end else if (valid_i) begin
      ready_o <= 1'b1;
      rdata_o <= mem[addr_i[WORD_BITS+1:2]];
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_sv32_mmu.sv
// Sv32 MMU testbench; root table at 0x1000, level-0 tables in the pages after it, below 64 KiB
`timescale 1ns/10ps
`default_nettype none

module tb_sv32_mmu;

  localparam int TIMEOUT_CYCLES = 200;
  localparam logic [31:0] ROOT   = 32'h0000_1000;
  // mode on, root ppn 1, asid 5 and asid 6
  localparam logic [31:0] SATP_A = 32'h8140_0001;
  localparam logic [31:0] SATP_B = 32'h8180_0001;

  logic        clk;
  logic        resetn;
  logic        tlb_flush;
  logic        valid;
  logic [31:0] address;
  logic [31:0] satp;
  logic        is_instruction;
  logic        ready;
  logic [31:0] pte;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic        mem_ready;
  logic [31:0] mem_rdata;

  integer      seed;
  string       test_name;
  logic [31:0] expected_pte;
  int          errors;
  int          test_start_errors;
  int          tests_passed;
  int          tests_failed;
  int          mem_valid_cycles;
  int          next_table;
  int          last_latency;
  int          last_mem_cycles;
  logic [31:0] last_pte;

  sv32_mmu i_dut (
    .clk              (clk),
    .resetn           (resetn),
    .tlb_flush_i      (tlb_flush),
    .valid_i          (valid),
    .address_i        (address),
    .satp_i           (satp),
    .is_instruction_i (is_instruction),
    .ready_o          (ready),
    .pte_o            (pte),
    .walk_mem_valid_o (mem_valid),
    .walk_mem_addr_o  (mem_addr),
    .walk_mem_ready_i (mem_ready),
    .walk_mem_rdata_i (mem_rdata)
  );

  pt_mem_model u_mem (
    .clk     (clk),
    .resetn  (resetn),
    .valid_i (mem_valid),
    .addr_i  (mem_addr),
    .ready_o (mem_ready),
    .rdata_o (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5;
      clk = ~clk;
    end
  end

  // expected pte, walked over the model's array
  function automatic logic [31:0] ref_translate(input logic [31:0] va, input logic [31:0] satp_v);
    logic [31:0] base;
    logic [31:0] slot;
    logic [31:0] entry;
    logic [31:0] result;
    logic        done;
    result = 32'h0;
    done   = 1'b0;
    if (!satp_v[31]) begin
      // bare: page-aligned address with v, r, w, x
      result = {va[31:12], 12'h00f};
      done   = 1'b1;
    end
    // physical addresses wrap at 32 bits, so only 20 ppn bits count
    base = {satp_v[19:0], 12'h000};
    for (int level = 1; level >= 0; level--) begin
      if (!done) begin
        slot  = base + {20'h0, (level == 1) ? va[31:22] : va[21:12], 2'b00};
        entry = u_mem.mem[slot[15:2]];
        if (!entry[0] || ((entry[3:1] == 3'b000) && (level == 0))) begin
          done = 1'b1;
        end else if (entry[3:1] == 3'b000) begin
          base = {entry[29:10], 12'h000};
        end else begin
          result = entry;
          // superpage keeps vpn[0] in the low ppn bits
          if (level == 1) begin
            result[19:10] = va[21:12];
          end
          done = 1'b1;
        end
      end
    end
    return result;
  endfunction

  // leaf flags: v set, at least one of r, w, x
  function automatic logic [31:0] random_leaf();
    logic [31:0] r;
    r    = $random(seed);
    r[0] = 1'b1;
    if (r[3:1] == 3'b000) begin
      r[1] = 1'b1;
    end
    return r;
  endfunction

  // two-level mapping, new level-0 table on first use of a vpn[1]
  task automatic map_4k(input logic [31:0] va, input logic [31:0] leaf);
    logic [31:0] root_slot;
    logic [31:0] l0_base;
    root_slot = ROOT + {20'h0, va[31:22], 2'b00};
    if (!u_mem.mem[root_slot[15:2]][0]) begin
      u_mem.write_word(root_slot, {2'b00, next_table[19:0], 10'h001});
      next_table = next_table + 1;
    end
    l0_base = {u_mem.mem[root_slot[15:2]][29:10], 12'h000};
    u_mem.write_word(l0_base + {20'h0, va[21:12], 2'b00}, leaf);
  endtask

  // latency counts edges after the one that samples valid
  task automatic run_request(input logic [31:0] va, input logic [31:0] satp_v,
                             input logic instr, input logic [31:0] exp_v);
    int cycles;
    int start_mem;
    @(posedge clk);
    #1;
    expected_pte   = exp_v;
    address        = va;
    satp           = satp_v;
    is_instruction = instr;
    valid          = 1'b1;
    start_mem      = mem_valid_cycles;
    @(posedge clk);
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!ready && (cycles < TIMEOUT_CYCLES));
    if (!ready) begin
      $display("test %s: no response, ready_o stayed low for %0d cycles", test_name, cycles);
      $display("sim failed");
      $finish;
    end else begin
      last_latency = cycles;
      last_pte     = pte;
      #1;
      valid           = 1'b0;
      last_mem_cycles = mem_valid_cycles - start_mem;
    end
  endtask

  task automatic open_test(input string name);
    test_name         = name;
    test_start_errors = errors;
  endtask

  task automatic close_test();
    if (errors == test_start_errors) begin
      $display("test %s: ok", test_name);
      tests_passed++;
    end else begin
      $display("test %s: failed with %0d errors", test_name, errors - test_start_errors);
      tests_failed++;
    end
  endtask

  // compare every response
  always @(posedge clk) begin
    if (resetn && ready && (pte !== expected_pte)) begin
      $display("Mismatch %s: expected %h, actual %h", test_name, expected_pte, pte);
      errors = errors + 1;
    end
  end

  // cycles with a walk read pending
  always @(posedge clk) begin
    if (resetn && mem_valid) begin
      mem_valid_cycles <= mem_valid_cycles + 1;
    end
  end

  initial begin
    logic [31:0] va;
    logic [31:0] old_pte;
    seed             = 32'h93e4;
    errors           = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    mem_valid_cycles = 0;
    next_table       = 2;
    test_name        = "reset";
    expected_pte     = 32'h0;
    resetn           = 1'b0;
    tlb_flush        = 1'b0;
    valid            = 1'b0;
    address          = 32'h0;
    satp             = 32'h0;
    is_instruction   = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    resetn = 1'b1;

    open_test("bare_mode");
    for (int i = 0; i < 4; i++) begin
      va = $random(seed);
      // asid and ppn bits must not matter with mode clear
      satp = $random(seed) & 32'h7fff_ffff;
      run_request(va, satp, va[0], ref_translate(va, satp));
      if (last_latency != 1) begin
        $display("Mismatch %s latency: expected 1, actual %0d", test_name, last_latency);
        errors++;
      end
      if (last_mem_cycles != 0) begin
        $display("test %s: a page table read happened in bare mode", test_name);
        errors++;
      end
    end
    close_test();

    open_test("translate_4k");
    for (int i = 0; i < 8; i++) begin
      va     = $random(seed);
      va[31] = 1'b0;
      map_4k(va, random_leaf());
      run_request(va, SATP_A, va[0], ref_translate(va, SATP_A));
    end
    close_test();

    open_test("superpage_fault");
    // leaf directly in the root table
    va            = $random(seed);
    va[31:22]     = 10'h3f0;
    u_mem.write_word(ROOT + {20'h0, va[31:22], 2'b00}, random_leaf());
    run_request(va, SATP_A, 1'b0, ref_translate(va, SATP_A));
    if (last_pte[19:10] !== va[21:12]) begin
      $display("Mismatch %s ppn low bits: expected %h, actual %h", test_name, va[21:12],
               last_pte[19:10]);
      errors++;
    end
    // root entry never written
    va[31:22] = 10'h3f1;
    run_request(va, SATP_A, 1'b0, 32'h0);
    // level-0 slot next to a mapped one stays empty
    va[31:22] = 10'h3f2;
    map_4k(va, random_leaf());
    va[12] = ~va[12];
    run_request(va, SATP_A, 1'b1, 32'h0);
    // pointer where a leaf must be
    va[13] = ~va[13];
    map_4k(va, 32'h0000_1401);
    run_request(va, SATP_A, 1'b0, 32'h0);
    close_test();

    open_test("tlb_hit");
    va        = $random(seed);
    va[31:30] = 2'b01;
    map_4k(va, random_leaf());
    old_pte = ref_translate(va, SATP_A);
    run_request(va, SATP_A, 1'b0, old_pte);
    // table changes behind the dtlb
    map_4k(va, old_pte ^ 32'h0000_0400);
    run_request(va, SATP_A, 1'b0, old_pte);
    if (last_latency != 2) begin
      $display("Mismatch %s latency: expected 2, actual %0d", test_name, last_latency);
      errors++;
    end
    if (last_mem_cycles != 0) begin
      $display("test %s: a page table read happened on a TLB hit", test_name);
      errors++;
    end
    close_test();

    open_test("separation_flush");
    // cached only in the dtlb
    run_request(va, SATP_A, 1'b1, ref_translate(va, SATP_A));
    if (last_mem_cycles == 0) begin
      $display("test %s: instruction request answered without a walk", test_name);
      errors++;
    end
    run_request(va, SATP_B, 1'b0, ref_translate(va, SATP_B));
    if (last_mem_cycles == 0) begin
      $display("test %s: request with another ASID answered without a walk", test_name);
      errors++;
    end
    @(posedge clk);
    #1;
    tlb_flush = 1'b1;
    @(posedge clk);
    #1;
    tlb_flush = 1'b0;
    map_4k(va, old_pte ^ 32'h0000_0800);
    run_request(va, SATP_A, 1'b0, ref_translate(va, SATP_A));
    if (last_mem_cycles == 0) begin
      $display("test %s: request after flush answered without a walk", test_name);
      errors++;
    end
    close_test();

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if ((tests_failed == 0) && (errors == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/mmu_pkg.sv
// MMU implementation types; tag layout and walker states depend on the Sv32 widths
package mmu_pkg;

  // tag is {vpn, asid}, so asid sits in the low bits
  localparam int TLB_TAG_BITS = sv32_pkg::VPN_BITS + sv32_pkg::SATP_ASID_BITS;

  typedef logic [TLB_TAG_BITS-1:0] tlb_tag_t;

  function automatic tlb_tag_t make_tag(sv32_pkg::vpn_t vpn, sv32_pkg::asid_t asid);
    return {vpn, asid};
  endfunction

  function automatic sv32_pkg::vpn_t tag_vpn(tlb_tag_t tag);
    return tag[sv32_pkg::SATP_ASID_BITS +: sv32_pkg::VPN_BITS];
  endfunction

  typedef enum logic [1:0] {
    st_idle,
    st_lookup,
    st_fetch
  } walk_state_t;

  localparam int NUM_TLBS = 2;

  typedef logic [$clog2(NUM_TLBS)-1:0] tlb_idx_t;

  // instruction fetches go to the itlb
  localparam tlb_idx_t TLB_DTLB = 1'b0;
  localparam tlb_idx_t TLB_ITLB = 1'b1;

endpackage

//--- verilog/sv32_mmu.sv
// Sv32 MMU top with ITLB and DTLB; single outstanding request, tlb_flush_i acts on the next edge
`timescale 1ns/10ps
`default_nettype none

module sv32_mmu #(
  parameter int ITLB_ENTRIES = 64,
  parameter int DTLB_ENTRIES = 64,
  parameter int ITLB_WAYS    = 4,
  parameter int DTLB_WAYS    = 4
) (
  input  wire logic            clk,
  input  wire logic            resetn,
  input  wire logic            tlb_flush_i,
  input  wire logic            valid_i,
  input  wire sv32_pkg::xlen_t address_i,
  input  wire sv32_pkg::xlen_t satp_i,
  input  wire logic            is_instruction_i,
  output logic                 ready_o,
  output sv32_pkg::xlen_t      pte_o,
  output logic                 walk_mem_valid_o,
  output sv32_pkg::xlen_t      walk_mem_addr_o,
  input  wire logic            walk_mem_ready_i,
  input  wire sv32_pkg::xlen_t walk_mem_rdata_i
);
  import mmu_pkg::*;

  // one lookup and fill link per tlb
  tlb_if tlb_bus [NUM_TLBS] ();

  sv32_walker u_walker (
    .clk              (clk),
    .resetn           (resetn),
    .valid_i          (valid_i),
    .address_i        (address_i),
    .satp_i           (satp_i),
    .is_instruction_i (is_instruction_i),
    .ready_o          (ready_o),
    .pte_o            (pte_o),
    .walk_mem_valid_o (walk_mem_valid_o),
    .walk_mem_addr_o  (walk_mem_addr_o),
    .walk_mem_ready_i (walk_mem_ready_i),
    .walk_mem_rdata_i (walk_mem_rdata_i),
    .tlbs             (tlb_bus)
  );

  // sizing picked per index, itlb or dtlb
  for (genvar g = 0; g < NUM_TLBS; g++) begin : g_tlb
    tlb_assoc #(
      .ENTRIES ((tlb_idx_t'(g) == TLB_ITLB) ? ITLB_ENTRIES : DTLB_ENTRIES),
      .WAYS    ((tlb_idx_t'(g) == TLB_ITLB) ? ITLB_WAYS : DTLB_WAYS)
    ) u_tlb (
      .clk     (clk),
      .resetn  (resetn),
      .flush_i (tlb_flush_i),
      .tlb     (tlb_bus[g])
    );
  end

endmodule

`default_nettype wire

//--- verilog/sv32_pkg.sv
// Sv32 formats only; physical page numbers are cut to 20 bits, so walks reach the low 4 GiB
package sv32_pkg;

  typedef logic [31:0] xlen_t;

  localparam int PAGE_OFFSET_BITS      = 12;
  localparam int VPN_PART_BITS         = 10;
  localparam int VPN_BITS              = 2 * VPN_PART_BITS;
  localparam int PTE_SHIFT             = 2;
  localparam int PTE_PPN_SHIFT         = 10;
  localparam int PTE_ALIGNED_PPN_SHIFT = 10;

  // pte flag bit positions
  localparam int PTE_V = 0;
  localparam int PTE_R = 1;
  localparam int PTE_W = 2;
  localparam int PTE_X = 3;
  localparam int PTE_U = 4;
  localparam int PTE_G = 5;
  localparam int PTE_A = 6;
  localparam int PTE_D = 7;

  // flags plus the two rsw bits
  localparam xlen_t PTE_FLAGS_MASK = 32'h0000_03ff;

  localparam int SATP_MODE_BIT  = 31;
  localparam int SATP_ASID_BITS = 9;
  localparam int SATP_PPN_BITS  = 22;

  typedef logic [VPN_PART_BITS-1:0]  vpn_part_t;
  typedef logic [VPN_BITS-1:0]       vpn_t;
  typedef logic [SATP_ASID_BITS-1:0] asid_t;
  typedef logic [SATP_PPN_BITS-1:0]  ppn_t;

  function automatic logic satp_mode(xlen_t satp);
    return satp[SATP_MODE_BIT];
  endfunction

  function automatic asid_t satp_asid(xlen_t satp);
    return satp[SATP_PPN_BITS +: SATP_ASID_BITS];
  endfunction

  function automatic ppn_t satp_ppn(xlen_t satp);
    return satp[SATP_PPN_BITS-1:0];
  endfunction

  function automatic vpn_t va_vpn(xlen_t va);
    return va[PAGE_OFFSET_BITS +: VPN_BITS];
  endfunction

  // level 1 picks vpn[1], level 0 picks vpn[0]
  function automatic vpn_part_t vpn_part(vpn_t vpn, logic level);
    return level ? vpn[VPN_PART_BITS +: VPN_PART_BITS] : vpn[VPN_PART_BITS-1:0];
  endfunction

  function automatic ppn_t pte_ppn(xlen_t pte);
    return pte[PTE_PPN_SHIFT +: SATP_PPN_BITS];
  endfunction

  // top two ppn bits fall off here
  function automatic xlen_t ppn_to_addr(ppn_t ppn);
    return xlen_t'({ppn, {PAGE_OFFSET_BITS{1'b0}}});
  endfunction

  // r, w and x all clear means next-level pointer
  function automatic logic pte_is_pointer(xlen_t pte);
    return !pte[PTE_R] && !pte[PTE_W] && !pte[PTE_X];
  endfunction

endpackage

//--- verilog/sv32_walker.sv
// one request at a time; inputs held until ready_o, no permission, a/d or alignment checks
`timescale 1ns/10ps
`default_nettype none

module sv32_walker (
  input  wire logic             clk,
  input  wire logic             resetn,
  input  wire logic             valid_i,
  input  wire sv32_pkg::xlen_t  address_i,
  input  wire sv32_pkg::xlen_t  satp_i,
  input  wire logic             is_instruction_i,
  output logic                  ready_o,
  output sv32_pkg::xlen_t       pte_o,
  output logic                  walk_mem_valid_o,
  output sv32_pkg::xlen_t       walk_mem_addr_o,
  input  wire logic             walk_mem_ready_i,
  input  wire sv32_pkg::xlen_t  walk_mem_rdata_i,
  tlb_if.walker                 tlbs [mmu_pkg::NUM_TLBS]
);
  import sv32_pkg::*;
  import mmu_pkg::*;

  walk_state_t state_q, state_nxt;
  logic        level_q, level_nxt;
  xlen_t       base_q, base_nxt;
  logic        ready_nxt;
  xlen_t       pte_nxt;

  tlb_idx_t      sel;
  vpn_t          vpn;
  tlb_tag_t      lookup_tag;
  logic [NUM_TLBS-1:0] hit_vec;
  xlen_t         rd_pte_vec [NUM_TLBS];
  logic          tlb_hit;
  xlen_t         tlb_rd_pte;
  ppn_t          leaf_ppn;
  xlen_t         leaf_pte;
  logic          fill;

  assign sel        = is_instruction_i ? TLB_ITLB : TLB_DTLB;
  assign vpn        = va_vpn(address_i);
  assign lookup_tag = make_tag(vpn, satp_asid(satp_i));

  // only the selected tlb sees lookup or fill
  for (genvar g = 0; g < NUM_TLBS; g++) begin : g_tlb_port
    assign tlbs[g].lookup_valid = (state_q == st_lookup) && (sel == tlb_idx_t'(g));
    assign tlbs[g].tag          = lookup_tag;
    assign tlbs[g].wr_en        = fill && (sel == tlb_idx_t'(g));
    assign tlbs[g].wr_pte       = leaf_pte;
    assign hit_vec[g]           = tlbs[g].hit;
    assign rd_pte_vec[g]        = tlbs[g].rd_pte;
  end

  assign tlb_hit    = hit_vec[sel];
  assign tlb_rd_pte = rd_pte_vec[sel];

  // pte slot at base + vpn[level] * 4
  assign walk_mem_valid_o = (state_q == st_fetch);
  assign walk_mem_addr_o  = base_q + (xlen_t'(vpn_part(vpn, level_q)) << PTE_SHIFT);

  // physical leaf; a superpage takes vpn[0] as its low ppn bits
  always_comb begin
    leaf_ppn = pte_ppn(walk_mem_rdata_i);
    if (level_q) begin
      leaf_ppn[VPN_PART_BITS-1:0] = vpn_part(vpn, 1'b0);
    end
    leaf_pte = (xlen_t'(leaf_ppn) << PTE_ALIGNED_PPN_SHIFT)
             | (walk_mem_rdata_i & PTE_FLAGS_MASK);
  end

  always_comb begin
    state_nxt = state_q;
    level_nxt = level_q;
    base_nxt  = base_q;
    pte_nxt   = pte_o;
    // ready is a single-cycle pulse
    ready_nxt = 1'b0;
    fill      = 1'b0;
    case (state_q)
      st_idle: begin
        // ready_o high means this request was just answered
        if (valid_i && !ready_o) begin
          if (!satp_mode(satp_i)) begin
            // identity map, page aligned with v, r, w and x set
            pte_nxt        = {address_i[31:PAGE_OFFSET_BITS], {PAGE_OFFSET_BITS{1'b0}}};
            pte_nxt[PTE_V] = 1'b1;
            pte_nxt[PTE_R] = 1'b1;
            pte_nxt[PTE_W] = 1'b1;
            pte_nxt[PTE_X] = 1'b1;
            ready_nxt      = 1'b1;
          end else begin
            base_nxt  = ppn_to_addr(satp_ppn(satp_i));
            level_nxt = 1'b1;
            state_nxt = st_lookup;
          end
        end
      end
      st_lookup: begin
        if (tlb_hit) begin
          pte_nxt   = tlb_rd_pte;
          ready_nxt = 1'b1;
          state_nxt = st_idle;
        end else begin
          state_nxt = st_fetch;
        end
      end
      st_fetch: begin
        // held here while memory stalls
        if (walk_mem_ready_i) begin
          if (!walk_mem_rdata_i[PTE_V]
              || (pte_is_pointer(walk_mem_rdata_i) && !level_q)) begin
            // fault marker
            pte_nxt   = '0;
            ready_nxt = 1'b1;
            state_nxt = st_idle;
          end else if (pte_is_pointer(walk_mem_rdata_i)) begin
            base_nxt  = ppn_to_addr(pte_ppn(walk_mem_rdata_i));
            level_nxt = 1'b0;
            state_nxt = st_lookup;
          end else begin
            pte_nxt   = leaf_pte;
            ready_nxt = 1'b1;
            fill      = 1'b1;
            state_nxt = st_idle;
          end
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q <= st_idle;
      level_q <= 1'b1;
      base_q  <= '0;
      pte_o   <= '0;
      ready_o <= 1'b0;
    end else begin
      state_q <= state_nxt;
      level_q <= level_nxt;
      base_q  <= base_nxt;
      pte_o   <= pte_nxt;
      ready_o <= ready_nxt;
    end
  end

endmodule

`default_nettype wire

//--- verilog/tlb_assoc.sv
// ENTRIES must be a power-of-two multiple of WAYS with at most 512 sets; flush wins over fill
`timescale 1ns/10ps
`default_nettype none

module tlb_assoc #(
  parameter int ENTRIES = 64,
  parameter int WAYS    = 4
) (
  input wire logic clk,
  input wire logic resetn,
  input wire logic flush_i,
  tlb_if.tlb       tlb
);
  import sv32_pkg::*;
  import mmu_pkg::*;

  localparam int SETS     = ENTRIES / WAYS;
  localparam int SET_BITS = (SETS > 1) ? $clog2(SETS) : 1;
  localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;
  // age 0 is most recent, AGE_MAX the eviction candidate
  localparam logic [WAY_BITS-1:0] AGE_MAX = WAY_BITS'(WAYS - 1);

  // payload storage, no reset
  tlb_tag_t tag_q [SETS][WAYS];
  xlen_t    pte_q [SETS][WAYS];

  // control state
  logic [WAYS-1:0]     valid_q [SETS];
  logic [WAY_BITS-1:0] age_q   [SETS][WAYS];

  logic [SET_BITS-1:0] set_idx;
  vpn_t                tag_vpn_bits;
  logic [WAYS-1:0]     match;
  logic                any_match;
  logic [WAY_BITS-1:0] hit_way;
  logic [WAY_BITS-1:0] victim;
  logic [WAY_BITS-1:0] touch_way;
  logic [WAY_BITS-1:0] touch_ref;
  logic                touch;

  // low tag bits are asid, xor in low vpn bits so one asid spreads over all sets
  always_comb begin
    tag_vpn_bits = tag_vpn(tlb.tag);
    if (SETS > 1) begin
      set_idx = tlb.tag[SET_BITS-1:0] ^ tag_vpn_bits[SET_BITS-1:0];
    end else begin
      set_idx = '0;
    end
  end

  // parallel compare of every way in the set
  always_comb begin
    match   = '0;
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (valid_q[set_idx][w] && (tag_q[set_idx][w] == tlb.tag)) begin
        match[w] = 1'b1;
        hit_way  = WAY_BITS'(w);
      end
    end
  end

  assign any_match  = |match;
  assign tlb.hit    = tlb.lookup_valid && any_match;
  assign tlb.rd_pte = pte_q[set_idx][hit_way];

  // oldest way first, any invalid way overrides, lowest index wins
  always_comb begin
    victim = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (age_q[set_idx][w] == AGE_MAX) begin
        victim = WAY_BITS'(w);
      end
    end
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!valid_q[set_idx][w]) begin
        victim = WAY_BITS'(w);
      end
    end
  end

  // refill of a present tag reuses its way
  assign touch     = tlb.wr_en || tlb.hit;
  assign touch_way = (tlb.wr_en && !any_match) ? victim : hit_way;
  // an invalid way counts as oldest, so every valid way ages
  assign touch_ref = valid_q[set_idx][touch_way] ? age_q[set_idx][touch_way] : AGE_MAX;

  always_ff @(posedge clk) begin
    if (!resetn || flush_i) begin
      for (int s = 0; s < SETS; s++) begin
        valid_q[s] <= '0;
        for (int w = 0; w < WAYS; w++) begin
          age_q[s][w] <= '0;
        end
      end
    end else if (touch) begin
      for (int w = 0; w < WAYS; w++) begin
        if (WAY_BITS'(w) == touch_way) begin
          age_q[set_idx][w] <= '0;
        end else if (valid_q[set_idx][w] && (age_q[set_idx][w] < touch_ref)) begin
          age_q[set_idx][w] <= age_q[set_idx][w] + 1'b1;
        end
      end
      if (tlb.wr_en) begin
        valid_q[set_idx][touch_way] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tlb.wr_en) begin
      tag_q[set_idx][touch_way] <= tlb.tag;
      pte_q[set_idx][touch_way] <= tlb.wr_pte;
    end
  end

endmodule

`default_nettype wire

//--- verilog/tlb_if.sv
// walker to TLB link; lookup answers in the same cycle, fill takes effect on the clock edge
`timescale 1ns/10ps
`default_nettype none

interface tlb_if;
  import sv32_pkg::*;
  import mmu_pkg::*;

  // lookup request, walker side
  logic     lookup_valid;
  tlb_tag_t tag;

  // lookup answer, combinational
  logic  hit;
  xlen_t rd_pte;

  // fill, same tag as the lookup
  logic  wr_en;
  xlen_t wr_pte;

  modport walker (
    output lookup_valid,
    output tag,
    output wr_en,
    output wr_pte,
    input  hit,
    input  rd_pte
  );

  modport tlb (
    input  lookup_valid,
    input  tag,
    input  wr_en,
    input  wr_pte,
    output hit,
    output rd_pte
  );

endinterface

`default_nettype wire
